//--- common/trace_pkg.sv
// shared widths, record types and packet encodings of the trace encoder
// every encoder module and the testbench import this package
package trace_pkg;

    // field widths of the retirement interface
    localparam int IADDR_W = 32;
    localparam int INSTR_W = 32;
    localparam int CAUSE_W = 5;
    localparam int TVAL_W  = 32;
    localparam int PRIV_W  = 2;

    // branch map holds up to 31 branches, count needs 5 bits
    localparam int BRANCH_MAP_LEN = 31;
    localparam int BRANCH_CNT_W   = 5;

    typedef logic [IADDR_W-1:0]        iaddr_t;
    typedef logic [INSTR_W-1:0]        instr_t;
    typedef logic [CAUSE_W-1:0]        cause_t;
    typedef logic [TVAL_W-1:0]         tval_t;
    typedef logic [PRIV_W-1:0]         priv_t;
    typedef logic [BRANCH_MAP_LEN-1:0] branch_map_t;
    typedef logic [BRANCH_CNT_W-1:0]   branch_cnt_t;

    // packet formats, format 0 is not generated
    typedef enum logic [1:0] {
        FMT_BRANCH_FULL = 2'd1,
        FMT_ADDR_ONLY   = 2'd2,
        FMT_SYNC        = 2'd3
    } trace_format_e;

    // subformats of a sync packet
    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } sync_subformat_e;

    // one retired instruction as reported by the core
    typedef struct packed {
        iaddr_t iaddr;
        instr_t instr;
        priv_t  priv;
        logic   exception;
        logic   interrupt;
        cause_t cause;
        tval_t  tval;
    } trace_instr_t;

    // decoded record kept in the tc/lc pipe, raw word already dropped
    typedef struct packed {
        iaddr_t iaddr;
        priv_t  priv;
        logic   exception;
        logic   interrupt;
        cause_t cause;
        tval_t  tval;
        logic   valid;
        logic   qualified;
        logic   is_branch;
        logic   updiscon;
    } trace_stage_t;

    // outgoing packet, fields unused by a format stay zero
    typedef struct packed {
        trace_format_e   format;
        sync_subformat_e subformat;
        priv_t           priv;
        iaddr_t          iaddr;
        logic            interrupt;
        cause_t          cause;
        tval_t           tval;
        branch_cnt_t     branches;
        branch_map_t     branch_map;
    } trace_packet_t;

endpackage

//--- filelist.f
+incdir+testbench
common/trace_pkg.sv
verilog/trace_stage_pipe.sv
verilog/trace_priority.sv
verilog/trace_branch_map.sv
verilog/trace_resync_counter.sv
verilog/trace_packet_emitter.sv
verilog/trace_encoder.sv
testbench/tb_trace_encoder.sv

//--- testbench/trace_ref_model.svh
// reference model of the encoder packet decisions, included in the testbench module
// apply_retirement() takes each retirement before the clock edge that samples it
`ifndef TRACE_REF_MODEL_SVH
`define TRACE_REF_MODEL_SVH

// model history, branch map, resync count and qualification state
trace_stage_t  model_tc;
trace_stage_t  model_lc;
branch_map_t   model_map;
branch_cnt_t   model_count;
int            model_resync;
logic          model_tracing;
// packets the DUT owes, checked one cycle after the deciding edge
trace_packet_t exp_q[$];

task automatic reset_model();
    model_tc      = '0;
    model_lc      = '0;
    model_map     = '0;
    model_count   = '0;
    model_resync  = 0;
    model_tracing = 1'b0;
    exp_q.delete();
endtask

// conditional branch opcode, jalr opcode, mret and sret words
function automatic trace_stage_t decode_record(input trace_instr_t ins, input logic en);
    trace_stage_t rec;
    rec           = '0;
    rec.iaddr     = ins.iaddr;
    rec.priv      = ins.priv;
    rec.exception = ins.exception;
    rec.interrupt = ins.interrupt;
    rec.cause     = ins.cause;
    rec.tval      = ins.tval;
    rec.valid     = 1'b1;
    rec.qualified = en;
    rec.is_branch = (ins.instr[6:0] == 7'b1100011);
    rec.updiscon  = (ins.instr[6:0] == 7'b1100111) || (ins.instr == 32'h3020_0073) ||
                    (ins.instr == 32'h1020_0073);
    return rec;
endfunction

task automatic apply_retirement(input trace_instr_t ins, input logic en);
    trace_stage_t  nc;
    trace_packet_t pkt;
    branch_map_t   la_map;
    branch_cnt_t   la_cnt;
    logic          commit;
    logic          emit;
    nc     = decode_record(ins, en);
    commit = model_tc.valid && model_tc.qualified;
    la_map = model_map;
    la_cnt = model_count;
    // taken when the successor is not at the fall-through address
    if (commit && model_tc.is_branch) begin
        la_map[la_cnt] = (ins.iaddr != model_tc.iaddr + 32'd4);
        la_cnt         = la_cnt + 1'b1;
    end
    emit           = 1'b0;
    pkt            = '0;
    pkt.iaddr      = model_tc.iaddr;
    pkt.branches   = la_cnt;
    pkt.branch_map = la_map;
    if (commit) begin
        emit = 1'b1;
        if (model_lc.valid && model_lc.qualified && model_lc.exception) begin
            pkt.format    = FMT_SYNC;
            pkt.subformat = SF_TRAP;
            pkt.priv      = model_tc.priv;
            pkt.interrupt = model_lc.interrupt;
            pkt.cause     = model_lc.cause;
            pkt.tval      = model_lc.tval;
        end else if (!model_tracing || (model_tc.priv != model_lc.priv) ||
                     (model_resync == RESYNC_MAX)) begin
            pkt.format    = FMT_SYNC;
            pkt.subformat = SF_START;
            pkt.priv      = model_tc.priv;
        end else if (model_lc.updiscon || !en || (la_cnt == BRANCH_MAP_LEN)) begin
            pkt.format = (la_cnt != 0) ? FMT_BRANCH_FULL : FMT_ADDR_ONLY;
        end else begin
            emit = 1'b0;
        end
    end
    if (emit) begin
        exp_q.push_back(pkt);
    end
    // every packet flushes the map, sync packets restart the resync count
    model_map   = emit ? '0 : la_map;
    model_count = emit ? '0 : la_cnt;
    if (emit && (pkt.format == FMT_SYNC)) begin
        model_resync = 0;
    end else if (commit && (model_resync < RESYNC_MAX)) begin
        model_resync++;
    end
    if (model_tc.valid && !en) begin
        model_tracing = 1'b0;
    end else if (commit) begin
        model_tracing = 1'b1;
    end
    model_lc = model_tc;
    model_tc = nc;
endtask

`endif

//--- testbench/tb_trace_encoder.sv
// testbench for the trace encoder
// six phases of random retirements, each packet checked against the included model
`timescale 1ns/1ps

module tb_trace_encoder;
    import trace_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int RESYNC_MAX    = 12;
    localparam int NUM_PHASES    = 6;
    localparam int PHASE_RETIRES = 400;
    // about 1.4 cycles per retirement at 70 %, so two per retirement is plenty
    localparam int MAX_CYCLES    = RESET_CYCLES + NUM_PHASES * PHASE_RETIRES * 2 + 64;

    logic          clk_i;
    logic          rst_ni;
    logic          iretired_i;
    logic          trace_enable_i;
    trace_instr_t  instr_i;
    logic          packet_valid_o;
    trace_packet_t packet_o;

    integer seed;
    int     error_count;
    int     check_count;
    int     packet_count;
    int     enable_run;
    iaddr_t pc;
    priv_t  cur_priv;
    string  phase_names [NUM_PHASES] = '{"start after reset", "trap", "branches and jalr",
                                         "long branch runs", "resync and privilege",
                                         "enable runs"};

    `include "trace_ref_model.svh"

    trace_encoder #(
        .RESYNC_MAX (RESYNC_MAX)
    ) UUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .iretired_i     (iretired_i),
        .trace_enable_i (trace_enable_i),
        .instr_i        (instr_i),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // word aligned jump or branch target
    function automatic iaddr_t rand_target();
        iaddr_t t;
        t      = $random(seed);
        t[1:0] = 2'b00;
        return t;
    endfunction

    task automatic check_format(input trace_format_e got_fmt, input trace_format_e exp_fmt,
                                input sync_subformat_e got_sf, input sync_subformat_e exp_sf);
        check_count++;
        if (got_fmt !== exp_fmt) begin
            $display("mismatch packet_o.format: got %h expected %h", got_fmt, exp_fmt);
            error_count++;
        end
        if (got_sf !== exp_sf) begin
            $display("mismatch packet_o.subformat: got %h expected %h", got_sf, exp_sf);
            error_count++;
        end
    endtask

    task automatic check_iaddr(input iaddr_t got_addr, input iaddr_t exp_addr,
                               input priv_t got_priv, input priv_t exp_priv);
        check_count++;
        if (got_addr !== exp_addr) begin
            $display("mismatch packet_o.iaddr: got %h expected %h", got_addr, exp_addr);
            error_count++;
        end
        if (got_priv !== exp_priv) begin
            $display("mismatch packet_o.priv: got %h expected %h", got_priv, exp_priv);
            error_count++;
        end
    endtask

    task automatic check_branches(input branch_cnt_t got_cnt, input branch_cnt_t exp_cnt,
                                  input branch_map_t got_map, input branch_map_t exp_map);
        check_count++;
        if (got_cnt !== exp_cnt) begin
            $display("mismatch packet_o.branches: got %h expected %h", got_cnt, exp_cnt);
            error_count++;
        end
        if (got_map !== exp_map) begin
            $display("mismatch packet_o.branch_map: got %h expected %h", got_map, exp_map);
            error_count++;
        end
    endtask

    task automatic check_trap(input logic got_int, input logic exp_int,
                              input cause_t got_cause, input cause_t exp_cause,
                              input tval_t got_tval, input tval_t exp_tval);
        check_count++;
        if (got_int !== exp_int) begin
            $display("mismatch packet_o.interrupt: got %h expected %h", got_int, exp_int);
            error_count++;
        end
        if (got_cause !== exp_cause) begin
            $display("mismatch packet_o.cause: got %h expected %h", got_cause, exp_cause);
            error_count++;
        end
        if (got_tval !== exp_tval) begin
            $display("mismatch packet_o.tval: got %h expected %h", got_tval, exp_tval);
            error_count++;
        end
    endtask

    // a queued packet is due in the cycle after its deciding edge
    task automatic check_outputs();
        trace_packet_t exp_pkt;
        if (packet_valid_o && (exp_q.size() == 0)) begin
            $display("unexpected packet_valid_o at %0t ns with no packet due", $time);
            error_count++;
        end else if (!packet_valid_o && (exp_q.size() != 0)) begin
            $display("missing packet_valid_o at %0t ns, packet for address %h not sent",
                     $time, exp_q[0].iaddr);
            void'(exp_q.pop_front());
            error_count++;
        end else if (packet_valid_o) begin
            exp_pkt = exp_q.pop_front();
            packet_count++;
            check_format(packet_o.format, exp_pkt.format, packet_o.subformat, exp_pkt.subformat);
            check_iaddr(packet_o.iaddr, exp_pkt.iaddr, packet_o.priv, exp_pkt.priv);
            check_branches(packet_o.branches, exp_pkt.branches,
                           packet_o.branch_map, exp_pkt.branch_map);
            check_trap(packet_o.interrupt, exp_pkt.interrupt, packet_o.cause, exp_pkt.cause,
                       packet_o.tval, exp_pkt.tval);
        end
    endtask

    task automatic make_stimulus(input int phase, input int retired);
        int unsigned br_pct;
        int unsigned jalr_pct;
        int unsigned pick;
        iaddr_t      next_pc;
        instr_t      word;
        iretired_i = (rand_below(10) < 7);
        if (iretired_i) begin
            // phase 1 starts unqualified, phase 6 toggles in runs
            if (phase == 1) begin
                trace_enable_i = (retired >= 24);
            end else if (phase == 6) begin
                if (enable_run == 0) begin
                    trace_enable_i = ~trace_enable_i;
                    enable_run     = 1 + rand_below(12);
                end
                enable_run--;
            end else begin
                trace_enable_i = 1'b1;
            end
            // occasional privilege change, often in phase 5
            if (rand_below((phase == 5) ? 10 : ((phase == 4) ? 1000 : 64)) == 0) begin
                cur_priv = priv_t'(rand_below(3));
                if (cur_priv == 2'd2) begin
                    cur_priv = 2'd3;
                end
            end
            br_pct   = (phase == 4) ? 92 : ((phase == 3) ? 40 : 25);
            jalr_pct = (phase == 4) ? 1 : ((phase == 3) ? 20 : 10);
            pick     = rand_below(100);
            word     = $random(seed);
            next_pc  = pc + 32'd4;
            if (pick < br_pct) begin
                word[6:0] = 7'b1100011;
                if (rand_below(2) == 0) begin
                    next_pc = rand_target();
                end
            end else if (pick < br_pct + jalr_pct) begin
                word[6:0] = 7'b1100111;
                next_pc   = rand_target();
            end else if (pick < br_pct + jalr_pct + 3) begin
                word    = rand_below(2) ? 32'h3020_0073 : 32'h1020_0073;
                next_pc = rand_target();
            end else begin
                word[6:0] = 7'b0110011;
            end
            instr_i       = '0;
            instr_i.iaddr = pc;
            instr_i.instr = word;
            instr_i.priv  = cur_priv;
            // rare traps, frequent in phase 2, continue at a handler
            if (rand_below((phase == 2) ? 8 : 128) == 0) begin
                instr_i.exception = 1'b1;
                instr_i.interrupt = (rand_below(4) == 0);
                instr_i.cause     = cause_t'(rand_below(32));
                instr_i.tval      = $random(seed);
                next_pc           = 32'h0000_0100 + iaddr_t'(rand_below(64) << 2);
            end
            pc = next_pc;
        end
    endtask

    task automatic run_phase(input int phase);
        int retired;
        int errors_before;
        int packets_before;
        retired        = 0;
        errors_before  = error_count;
        packets_before = packet_count;
        while (retired < PHASE_RETIRES) begin
            @(negedge clk_i);
            check_outputs();
            make_stimulus(phase, retired);
            if (iretired_i) begin
                apply_retirement(instr_i, trace_enable_i);
                retired++;
            end
        end
        $display("phase %0d (%s): %0d packets, %0d errors", phase, phase_names[phase - 1],
                 packet_count - packets_before, error_count - errors_before);
    endtask

    initial begin
        seed           = 32'hf60a_6ebc;
        error_count    = 0;
        check_count    = 0;
        packet_count   = 0;
        enable_run     = 0;
        pc             = 32'h0000_1000;
        cur_priv       = 2'd3;
        rst_ni         = 1'b0;
        iretired_i     = 1'b0;
        trace_enable_i = 1'b0;
        instr_i        = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int phase = 1; phase <= NUM_PHASES; phase++) begin
            run_phase(phase);
        end
        // drain the last pending packet
        repeat (4) begin
            @(negedge clk_i);
            check_outputs();
            iretired_i = 1'b0;
        end
        $display("summary: %0d packets, %0d checks, %0d errors",
                 packet_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog sized from the phase lengths
    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("watchdog timeout, stimulus did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- verilog/trace_branch_map.sv
// branch map, one direction bit per committed branch since the last packet
// outputs already include the branch committed this cycle
// a flush on the commit edge empties the map after it has been sent
`timescale 1ns/1ps

module trace_branch_map (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    commit_i,
    input  trace_pkg::trace_stage_t tc_i,
    input  logic                    taken_i,
    input  logic                    flush_i,
    output trace_pkg::branch_map_t  map_o,
    output trace_pkg::branch_cnt_t  count_o,
    output logic                    full_o
);
    import trace_pkg::*;

    branch_map_t map_q;
    branch_map_t map_d;
    branch_cnt_t count_q;
    branch_cnt_t count_d;
    logic        append;

    assign append = commit_i && tc_i.is_branch;

    // lookahead, bit 0 holds the oldest branch
    always_comb begin
        map_d   = map_q;
        count_d = count_q;
        if (append) begin
            map_d[count_q] = taken_i;
            count_d        = count_q + 1'b1;
        end
    end

    assign map_o   = map_d;
    assign count_o = count_d;
    assign full_o  = (count_d == BRANCH_CNT_W'(BRANCH_MAP_LEN));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            map_q   <= '0;
            count_q <= '0;
        end else begin
            map_q   <= map_d;
            count_q <= count_d;
        end
    end

    // a full map always forces a packet, so a full count is never stored
    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        count_q < BRANCH_CNT_W'(BRANCH_MAP_LEN)
    );

endmodule

//--- verilog/trace_encoder.sv
// top level of the instruction trace encoder
// watches the retirement stream and emits one packet struct per packet decision
// RESYNC_MAX sets the number of commits between forced sync packets
`timescale 1ns/1ps

module trace_encoder #(
    parameter int RESYNC_MAX = 64
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     iretired_i,
    input  logic                     trace_enable_i,
    input  trace_pkg::trace_instr_t  instr_i,
    output logic                     packet_valid_o,
    output trace_pkg::trace_packet_t packet_o
);
    import trace_pkg::*;

    // tc/lc view of the instruction stream
    trace_stage_t    tc;
    trace_stage_t    lc;
    logic            tc_taken;
    // priority decision
    logic            commit;
    logic            emit;
    trace_format_e   pkt_format;
    sync_subformat_e pkt_subformat;
    // branch map lookahead
    branch_map_t     br_map;
    branch_cnt_t     br_count;
    logic            br_full;
    // resync timer
    logic            resync_expired;

    trace_stage_pipe i_stage_pipe (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .iretired_i     (iretired_i),
        .trace_enable_i (trace_enable_i),
        .instr_i        (instr_i),
        .tc_o           (tc),
        .lc_o           (lc),
        .tc_taken_o     (tc_taken)
    );

    trace_priority i_priority (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .iretired_i     (iretired_i),
        .trace_enable_i (trace_enable_i),
        .tc_i           (tc),
        .lc_i           (lc),
        .full_i         (br_full),
        .expired_i      (resync_expired),
        .count_i        (br_count),
        .commit_o       (commit),
        .emit_o         (emit),
        .format_o       (pkt_format),
        .subformat_o    (pkt_subformat)
    );

    // every emitted packet carries and empties the map
    trace_branch_map i_branch_map (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .commit_i (commit),
        .tc_i     (tc),
        .taken_i  (tc_taken),
        .flush_i  (emit),
        .map_o    (br_map),
        .count_o  (br_count),
        .full_o   (br_full)
    );

    trace_resync_counter #(
        .RESYNC_MAX (RESYNC_MAX)
    ) i_resync_counter (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .commit_i  (commit),
        .emit_i    (emit),
        .format_i  (pkt_format),
        .expired_o (resync_expired)
    );

    trace_packet_emitter i_packet_emitter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .emit_i         (emit),
        .format_i       (pkt_format),
        .subformat_i    (pkt_subformat),
        .tc_i           (tc),
        .lc_i           (lc),
        .map_i          (br_map),
        .count_i        (br_count),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o)
    );

endmodule

//--- verilog/trace_packet_emitter.sv
// builds the packet struct from the priority decision and registers it
// packet_valid_o pulses for one cycle after each decision that emits
`timescale 1ns/1ps

module trace_packet_emitter (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       emit_i,
    input  trace_pkg::trace_format_e   format_i,
    input  trace_pkg::sync_subformat_e subformat_i,
    input  trace_pkg::trace_stage_t    tc_i,
    input  trace_pkg::trace_stage_t    lc_i,
    input  trace_pkg::branch_map_t     map_i,
    input  trace_pkg::branch_cnt_t     count_i,
    output logic                       packet_valid_o,
    output trace_pkg::trace_packet_t   packet_o
);
    import trace_pkg::*;

    trace_packet_t pkt_d;
    trace_packet_t pkt_q;
    logic          valid_q;
    logic          is_sync;
    logic          is_trap;

    assign is_sync = (format_i == FMT_SYNC);
    assign is_trap = is_sync && (subformat_i == SF_TRAP);

    always_comb begin
        // unused fields stay zero
        pkt_d            = '0;
        pkt_d.format     = format_i;
        // address is always full and always from tc
        pkt_d.iaddr      = tc_i.iaddr;
        pkt_d.branches   = count_i;
        pkt_d.branch_map = map_i;
        if (is_sync) begin
            pkt_d.subformat = subformat_i;
            pkt_d.priv      = tc_i.priv;
        end
        // trap details come from the trapping lc instruction
        if (is_trap) begin
            pkt_d.interrupt = lc_i.interrupt;
            pkt_d.cause     = lc_i.cause;
            pkt_d.tval      = lc_i.tval;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= emit_i;
        end
    end

    // payload only loads with a packet
    always_ff @(posedge clk_i) begin
        if (emit_i) begin
            pkt_q <= pkt_d;
        end
    end

    assign packet_valid_o = valid_q;
    assign packet_o       = pkt_q;

endmodule

//--- verilog/trace_priority.sv
// qualification FSM and packet priority decision
// decides the tc instruction when the next retirement arrives
// combinational apart from the qualification state register
`timescale 1ns/1ps

module trace_priority (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       iretired_i,
    input  logic                       trace_enable_i,
    input  trace_pkg::trace_stage_t    tc_i,
    input  trace_pkg::trace_stage_t    lc_i,
    input  logic                       full_i,
    input  logic                       expired_i,
    input  trace_pkg::branch_cnt_t     count_i,
    output logic                       commit_o,
    output logic                       emit_o,
    output trace_pkg::trace_format_e   format_o,
    output trace_pkg::sync_subformat_e subformat_o
);
    import trace_pkg::*;

    typedef enum logic {
        QUAL_OFF,
        QUAL_TRACING
    } qual_state_e;

    qual_state_e state_q;
    qual_state_e state_d;
    logic        decide;
    logic        trap_pkt;
    logic        start_pkt;
    logic        disc_pkt;

    // tc is decided once its successor retires
    assign decide   = iretired_i && tc_i.valid;
    assign commit_o = decide && tc_i.qualified;

    // previous instruction trapped
    assign trap_pkt  = lc_i.valid && lc_i.qualified && lc_i.exception;
    // first qualified instruction, privilege change or resync due
    assign start_pkt = (state_q == QUAL_OFF) || (tc_i.priv != lc_i.priv) || expired_i;
    // uninferable jump, last qualified instruction or full map
    assign disc_pkt  = lc_i.updiscon || !trace_enable_i || full_i;

    always_comb begin
        emit_o      = 1'b0;
        format_o    = FMT_ADDR_ONLY;
        subformat_o = SF_START;
        if (commit_o) begin
            if (trap_pkt) begin
                emit_o      = 1'b1;
                format_o    = FMT_SYNC;
                subformat_o = SF_TRAP;
            end else if (start_pkt) begin
                emit_o      = 1'b1;
                format_o    = FMT_SYNC;
                subformat_o = SF_START;
            end else if (disc_pkt) begin
                emit_o = 1'b1;
                // address only when there are no branches to report
                if (count_i != '0) begin
                    format_o = FMT_BRANCH_FULL;
                end else begin
                    format_o = FMT_ADDR_ONLY;
                end
            end
        end
    end

    // qualification FSM
    always_comb begin
        state_d = state_q;
        if (decide && !trace_enable_i) begin
            // nc drops out of the trace
            state_d = QUAL_OFF;
        end else if (commit_o) begin
            state_d = QUAL_TRACING;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= QUAL_OFF;
        end else begin
            state_q <= state_d;
        end
    end

    // while tracing, the pipe holds a qualified tc after a qualified lc
    a_tracing_pipe: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (state_q == QUAL_TRACING) |-> (tc_i.qualified && lc_i.valid && lc_i.qualified)
    );

endmodule

//--- verilog/trace_resync_counter.sv
// counts committed instructions since the last sync packet
// flags expiry at RESYNC_MAX so that the next commit sends a sync
`timescale 1ns/1ps

module trace_resync_counter #(
    parameter int RESYNC_MAX = 64
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     commit_i,
    input  logic                     emit_i,
    input  trace_pkg::trace_format_e format_i,
    output logic                     expired_o
);
    import trace_pkg::*;

    localparam int CNT_W = $clog2(RESYNC_MAX + 1);

    logic [CNT_W-1:0] count_q;
    logic             sync;

    // any format 3 packet, start or trap, resynchronises the decoder
    assign sync      = emit_i && (format_i == FMT_SYNC);
    assign expired_o = (count_q == CNT_W'(RESYNC_MAX));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (sync) begin
            count_q <= '0;
        end else if (commit_i && !expired_o) begin
            // saturate until the sync goes out
            count_q <= count_q + 1'b1;
        end
    end

    // expiry is never left pending past a commit
    a_expiry_syncs: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (commit_i && expired_o) |-> sync
    );

endmodule

//--- verilog/trace_stage_pipe.sv
// two-deep record pipe holding the this-cycle and last-cycle instructions
// the retirement on the input acts as the next-cycle instruction
// advances only on retirement, decodes branch and discontinuity on capture
`timescale 1ns/1ps

module trace_stage_pipe (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    iretired_i,
    input  logic                    trace_enable_i,
    input  trace_pkg::trace_instr_t instr_i,
    output trace_pkg::trace_stage_t tc_o,
    output trace_pkg::trace_stage_t lc_o,
    output logic                    tc_taken_o
);
    import trace_pkg::*;

    // RV32 opcodes and system words that matter for tracing
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam instr_t     MRET_WORD  = 32'h3020_0073;
    localparam instr_t     SRET_WORD  = 32'h1020_0073;

    trace_stage_t tc_q;
    trace_stage_t lc_q;
    trace_stage_t nc_stage;
    logic [6:0]   opcode;
    iaddr_t       tc_seq_addr;

    assign opcode = instr_i.instr[6:0];

    // decode the incoming word into a stage record
    always_comb begin
        nc_stage.iaddr     = instr_i.iaddr;
        nc_stage.priv      = instr_i.priv;
        nc_stage.exception = instr_i.exception;
        nc_stage.interrupt = instr_i.interrupt;
        nc_stage.cause     = instr_i.cause;
        nc_stage.tval      = instr_i.tval;
        nc_stage.valid     = 1'b1;
        // qualification comes straight from the enable
        nc_stage.qualified = trace_enable_i;
        nc_stage.is_branch = (opcode == OPC_BRANCH);
        // target of jalr or xret cannot be read from the binary
        nc_stage.updiscon  = (opcode == OPC_JALR) ||
                             (instr_i.instr == MRET_WORD) ||
                             (instr_i.instr == SRET_WORD);
    end

    // all instructions are 4 bytes wide
    assign tc_seq_addr = tc_q.iaddr + IADDR_W'(4);

    // nc address off the fall-through path means the tc branch was taken
    assign tc_taken_o = tc_q.valid && tc_q.is_branch && (instr_i.iaddr != tc_seq_addr);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tc_q <= '0;
            lc_q <= '0;
        end else if (iretired_i) begin
            // shift on every retirement
            lc_q <= tc_q;
            tc_q <= nc_stage;
        end
    end

    assign tc_o = tc_q;
    assign lc_o = lc_q;

endmodule
